/* rtl/conv_types_pkg.sv */
package conv_types_pkg;

    ////////////////////////////////////////////////////////////
    // Array shape and fixed arithmetic
    ////////////////////////////////////////////////////////////
    localparam int SA_ROWS     = 8;                 // Output channels
    localparam int ROW_W       = $clog2(SA_ROWS);
    localparam int QUANT_SHIFT = 6;
    localparam int LEAKY_SHIFT = 3;                 // Negative slope of 1/8
    localparam int Q_MAX       = 127;
    localparam int Q_MIN       = -128;

    // Value types
    typedef logic signed [7:0]  pix_t;
    typedef logic signed [7:0]  wgt_t;
    typedef logic signed [23:0] acc_t;
    typedef logic signed [15:0] bias_t;
    typedef logic signed [7:0]  q_t;

    // One weight per output channel, row 0 in the low byte
    typedef struct packed {
        wgt_t [SA_ROWS-1:0] w;
    } wgt_vec_t;

    typedef struct packed {
        bias_t [SA_ROWS-1:0] b;
    } bias_vec_t;

    typedef struct packed {
        logic [ROW_W-1:0] row;
        q_t               q;
    } out_word_t;

endpackage

/* rtl/sa_seq_pkg.sv */
package sa_seq_pkg;

    ////////////////////////////////////////////////////////////
    // Sequencer sizing
    ////////////////////////////////////////////////////////////
    localparam int OUT_CREDITS = 4;     // Words the consumer can hold
    localparam int PP_DEPTH    = 3;     // Registered post-processing stages

    typedef logic [15:0]                       pix_cnt_t;
    typedef logic [conv_types_pkg::ROW_W-1:0]  row_idx_t;
    typedef logic [2:0]                        credit_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCUM,
        DRAIN
    } sa_state_e;

    // Control that rides along with each row through post-processing
    typedef struct packed {
        logic     valid;
        logic     leaky;        // Leaky ReLU instead of plain ReLU
        row_idx_t row;
    } stage_ctrl_t;

endpackage

/* rtl/sa_ctrl.sv */
`timescale 1ns/1ps

module sa_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  sa_seq_pkg::pix_cnt_t    last_pix,
    input  logic                    pix_valid,
    input  logic                    mode,
    input  logic                    credit_ret,
    output logic                    acc_clr,
    output logic                    acc_en,
    output sa_seq_pkg::row_idx_t    rd_row,
    output sa_seq_pkg::stage_ctrl_t issue,
    output logic                    busy,
    output sa_seq_pkg::credit_t     credits
);

    sa_seq_pkg::sa_state_e           state_q;
    sa_seq_pkg::sa_state_e           state_d;
    sa_seq_pkg::pix_cnt_t            pix_cnt_q;
    sa_seq_pkg::pix_cnt_t            last_pix_q;
    sa_seq_pkg::row_idx_t            row_q;
    sa_seq_pkg::credit_t             credit_q;
    logic                            mode_q;
    logic [sa_seq_pkg::PP_DEPTH-1:0] tail_q;     // Row 7 still in post-proc
    logic                            start_ok;
    logic                            do_issue;
    logic                            last_row;

    ////////////////////////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////////////////////////
    assign busy     = (state_q != sa_seq_pkg::IDLE) || (|tail_q);
    assign start_ok = start && !busy;

    // Start cycle carries pixel 0
    assign acc_clr = start_ok;
    assign acc_en  = pix_valid && (start_ok || state_q == sa_seq_pkg::ACCUM);

    assign do_issue = (state_q == sa_seq_pkg::DRAIN) && (credit_q != '0);
    assign last_row = (row_q == sa_seq_pkg::row_idx_t'(conv_types_pkg::SA_ROWS - 1));

    assign rd_row = row_q;
    assign issue  = '{valid: do_issue, leaky: mode_q, row: row_q};

    assign credits = credit_q;

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            sa_seq_pkg::IDLE: begin
                if (start_ok) begin
                    // Single-pixel tile skips ACCUM
                    state_d = (last_pix == '0) ? sa_seq_pkg::DRAIN : sa_seq_pkg::ACCUM;
                end
            end
            sa_seq_pkg::ACCUM: begin
                if (pix_cnt_q == last_pix_q) begin
                    state_d = sa_seq_pkg::DRAIN;
                end
            end
            sa_seq_pkg::DRAIN: begin
                if (do_issue && last_row) begin
                    state_d = sa_seq_pkg::IDLE;
                end
            end
            default: state_d = sa_seq_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= sa_seq_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Pixel counter and tile parameters
    always_ff @(posedge clk) begin
        if (reset) begin
            pix_cnt_q  <= '0;
            last_pix_q <= '0;
            mode_q     <= 1'b0;
        end else if (start_ok) begin
            pix_cnt_q  <= sa_seq_pkg::pix_cnt_t'(1);   // Pixel 0 taken this cycle
            last_pix_q <= last_pix;
            mode_q     <= mode;
        end else if (state_q == sa_seq_pkg::ACCUM) begin
            pix_cnt_q <= pix_cnt_q + 1'b1;
        end
    end

    // Drain row, advances only on issue
    always_ff @(posedge clk) begin
        if (reset) begin
            row_q <= '0;
        end else if (do_issue) begin
            row_q <= last_row ? '0 : row_q + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output credits and pipeline tail
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_q <= sa_seq_pkg::credit_t'(sa_seq_pkg::OUT_CREDITS);
        end else begin
            credit_q <= credit_q + sa_seq_pkg::credit_t'(credit_ret)
                                 - sa_seq_pkg::credit_t'(do_issue);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tail_q <= '0;
        end else begin
            tail_q <= {tail_q[sa_seq_pkg::PP_DEPTH-2:0], do_issue && last_row};
        end
    end

endmodule

/* rtl/sa_array.sv */
`timescale 1ns/1ps

module sa_array (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     acc_clr,
    input  logic                     acc_en,
    input  conv_types_pkg::pix_t     pix,
    input  conv_types_pkg::wgt_vec_t wgts,
    input  sa_seq_pkg::row_idx_t     rd_row,
    output conv_types_pkg::acc_t     rd_acc
);

    conv_types_pkg::acc_t acc_q [conv_types_pkg::SA_ROWS];
    conv_types_pkg::acc_t prod  [conv_types_pkg::SA_ROWS];

    ////////////////////////////////////////////////////////////
    // Multipliers, one per output channel
    ////////////////////////////////////////////////////////////
    always_comb begin
        for (int r = 0; r < conv_types_pkg::SA_ROWS; r++) begin
            // Feature word is broadcast to every row
            prod[r] = $signed(pix) * $signed(wgts.w[r]);
        end
    end

    ////////////////////////////////////////////////////////////
    // Accumulators
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int r = 0; r < conv_types_pkg::SA_ROWS; r++) begin
            if (reset) begin
                acc_q[r] <= '0;
            end else if (acc_en) begin
                if (acc_clr) begin
                    acc_q[r] <= prod[r];            // First product loads
                end else begin
                    acc_q[r] <= acc_q[r] + prod[r];
                end
            end else if (acc_clr) begin
                acc_q[r] <= '0;                     // Start without a pixel
            end
        end
    end

    // Drain read port
    assign rd_acc = acc_q[rd_row];

endmodule

/* rtl/post_proc.sv */
`timescale 1ns/1ps

module post_proc (
    input  logic                      clk,
    input  logic                      reset,
    input  sa_seq_pkg::stage_ctrl_t   issue,
    input  conv_types_pkg::acc_t      acc,
    input  conv_types_pkg::bias_vec_t bias,
    output logic                      out_valid,
    output conv_types_pkg::out_word_t out_word,
    output logic                      last_out
);

    sa_seq_pkg::stage_ctrl_t s1_ctrl;
    sa_seq_pkg::stage_ctrl_t s2_ctrl;
    sa_seq_pkg::stage_ctrl_t s3_ctrl;
    conv_types_pkg::acc_t    bias_ext;
    conv_types_pkg::acc_t    s1_sum;
    conv_types_pkg::acc_t    act_d;
    conv_types_pkg::acc_t    s2_act;
    conv_types_pkg::acc_t    shifted;
    conv_types_pkg::q_t      sat_d;
    conv_types_pkg::q_t      s3_q;

    // Control travels with the data through all three stages
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_ctrl <= '0;
            s2_ctrl <= '0;
            s3_ctrl <= '0;
        end else begin
            s1_ctrl <= issue;
            s2_ctrl <= s1_ctrl;
            s3_ctrl <= s2_ctrl;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 1, bias add
    ////////////////////////////////////////////////////////////
    assign bias_ext = bias.b[issue.row];        // Sign extended to acc width

    always_ff @(posedge clk) begin
        s1_sum <= acc + bias_ext;
    end

    ////////////////////////////////////////////////////////////
    // Stage 2, tail activation
    ////////////////////////////////////////////////////////////
    always_comb begin
        if (!s1_sum[$bits(conv_types_pkg::acc_t)-1]) begin
            act_d = s1_sum;
        end else if (s1_ctrl.leaky) begin
            act_d = s1_sum >>> conv_types_pkg::LEAKY_SHIFT;
        end else begin
            act_d = '0;                         // Plain ReLU
        end
    end

    always_ff @(posedge clk) begin
        s2_act <= act_d;
    end

    ////////////////////////////////////////////////////////////
    // Stage 3, quantize and saturate
    ////////////////////////////////////////////////////////////
    always_comb begin
        shifted = s2_act >>> conv_types_pkg::QUANT_SHIFT;
        if (shifted > conv_types_pkg::Q_MAX) begin
            sat_d = conv_types_pkg::q_t'(conv_types_pkg::Q_MAX);
        end else if (shifted < conv_types_pkg::Q_MIN) begin
            sat_d = conv_types_pkg::q_t'(conv_types_pkg::Q_MIN);
        end else begin
            sat_d = conv_types_pkg::q_t'(shifted);
        end
    end

    always_ff @(posedge clk) begin
        s3_q <= sat_d;
    end

    assign out_valid = s3_ctrl.valid;
    assign out_word  = '{row: s3_ctrl.row, q: s3_q};
    assign last_out  = s3_ctrl.valid &&
        (s3_ctrl.row == sa_seq_pkg::row_idx_t'(conv_types_pkg::SA_ROWS - 1));

endmodule

/* rtl/conv_tile_top.sv */
`timescale 1ns/1ps

module conv_tile_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  sa_seq_pkg::pix_cnt_t      last_pix,
    input  logic                      pix_valid,
    input  conv_types_pkg::pix_t      pix,
    input  conv_types_pkg::wgt_vec_t  wgts,
    input  conv_types_pkg::bias_vec_t bias,
    input  logic                      mode,
    input  logic                      credit_ret,
    output logic                      out_valid,
    output conv_types_pkg::out_word_t out_word,
    output logic                      tile_done,
    output logic                      busy
);

    logic                      acc_clr;
    logic                      acc_en;
    sa_seq_pkg::row_idx_t      rd_row;
    sa_seq_pkg::stage_ctrl_t   issue;
    conv_types_pkg::acc_t      rd_acc;
    conv_types_pkg::bias_vec_t bias_q;
    logic                      last_out;

    // Biases held for the whole tile
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            bias_q <= bias;
        end
    end

    ////////////////////////////////////////////////////////////
    // Sequencer, array and post-processing
    ////////////////////////////////////////////////////////////
    sa_ctrl u_sa_ctrl (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .last_pix   (last_pix),
        .pix_valid  (pix_valid),
        .mode       (mode),
        .credit_ret (credit_ret),
        .acc_clr    (acc_clr),
        .acc_en     (acc_en),
        .rd_row     (rd_row),
        .issue      (issue),
        .busy       (busy),
        .credits    ()              // Observed by the bound checker only
    );

    sa_array u_sa_array (
        .clk     (clk),
        .reset   (reset),
        .acc_clr (acc_clr),
        .acc_en  (acc_en),
        .pix     (pix),
        .wgts    (wgts),
        .rd_row  (rd_row),
        .rd_acc  (rd_acc)
    );

    post_proc u_post_proc (
        .clk       (clk),
        .reset     (reset),
        .issue     (issue),
        .acc       (rd_acc),
        .bias      (bias_q),
        .out_valid (out_valid),
        .out_word  (out_word),
        .last_out  (last_out)
    );

    assign tile_done = last_out;    // Row 7 leaving the pipeline

endmodule

/* tb/conv_tile_sva.sv */
`timescale 1ns/1ps

module conv_tile_sva (
    input logic                    clk,
    input logic                    reset,
    input logic                    start,
    input logic                    busy,
    input logic                    credit_ret,
    input sa_seq_pkg::stage_ctrl_t issue,
    input sa_seq_pkg::credit_t     credits
);

    int in_flight;      // Rows issued and not yet paid back

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= 0;
        end else begin
            in_flight <= in_flight + int'(issue.valid) - int'(credit_ret);
        end
    end

    ////////////////////////////////////////////////////////////
    // Credit accounting
    ////////////////////////////////////////////////////////////
    a_credits_bounded: assert property (@(posedge clk) disable iff (reset)
        credits <= sa_seq_pkg::credit_t'(sa_seq_pkg::OUT_CREDITS))
        else $error("credit count %0d above the limit", credits);

    // Drain must hold with an empty credit pool
    a_no_issue_empty: assert property (@(posedge clk) disable iff (reset)
        issue.valid |-> in_flight < sa_seq_pkg::OUT_CREDITS)
        else $error("row issued with zero credits");

    // Busy only rises after an accepted start
    a_busy_after_start: assert property (@(posedge clk) disable iff (reset)
        $rose(busy) |-> $past(start))
        else $error("busy rose without a start");

    ////////////////////////////////////////////////////////////
    // Reset values
    ////////////////////////////////////////////////////////////
    a_reset_values: assert property (@(posedge clk)
        reset |=> (!busy && !issue.valid &&
                   credits == sa_seq_pkg::credit_t'(sa_seq_pkg::OUT_CREDITS)))
        else $error("sequencer not idle after reset");

endmodule

bind sa_ctrl conv_tile_sva u_conv_tile_sva (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .busy       (busy),
    .credit_ret (credit_ret),
    .issue      (issue),
    .credits    (credits)
);

/* tb/conv_tile_tb.sv */
`timescale 1ns/1ps

module conv_tile_tb;

    localparam int NUM_TILES  = 12;
    localparam int MAX_PIX    = 41;         // last_pix up to 40
    localparam int WAIT_LIMIT = 4000;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      start;
    sa_seq_pkg::pix_cnt_t      last_pix;
    logic                      pix_valid;
    conv_types_pkg::pix_t      pix;
    conv_types_pkg::wgt_vec_t  wgts;
    conv_types_pkg::bias_vec_t bias;
    logic                      mode;
    logic                      credit_ret = 1'b0;
    logic                      out_valid;
    conv_types_pkg::out_word_t out_word;
    logic                      tile_done;
    logic                      busy;

    logic [31:0]               stim_lfsr = 32'haaeb;
    logic [31:0]               cons_lfsr = 32'haaeb;
    conv_types_pkg::out_word_t exp_q [$];   // Model results in arrival order
    int                        recv_cnt = 0;
    int                        ret_cnt = 0;
    int                        done_cnt = 0;
    int                        delay_cnt = 0;
    logic                      stingy = 1'b0;  // Slow consumer for this tile
    logic                      busy_exp = 1'b0;
    int                        mismatches = 0;
    int                        mon_errs = 0;
    int                        protocol_errs = 0;
    int                        timeouts = 0;

    always #50 clk = ~clk;

    conv_tile_top u_conv_tile_top (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .last_pix   (last_pix),
        .pix_valid  (pix_valid),
        .pix        (pix),
        .wgts       (wgts),
        .bias       (bias),
        .mode       (mode),
        .credit_ret (credit_ret),
        .out_valid  (out_valid),
        .out_word   (out_word),
        .tile_done  (tile_done),
        .busy       (busy)
    );

    ////////////////////////////////////////////////////////////
    // Random source and reference model
    ////////////////////////////////////////////////////////////
    task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            st = {st[30:0], st[31] ^ st[21] ^ st[1] ^ st[0]};   // Taps 32 22 2 1
            v  = {v[30:0], st[0]};
        end
    endtask

    function automatic conv_types_pkg::q_t model_result(input int dot, input int b,
                                                        input logic leaky);
        int v;
        v = dot + b;
        if (v < 0) begin
            v = leaky ? (v >>> conv_types_pkg::LEAKY_SHIFT) : 0;
        end
        v = v >>> conv_types_pkg::QUANT_SHIFT;
        if (v > 127) begin
            v = 127;
        end else if (v < -128) begin
            v = -128;
        end
        return conv_types_pkg::q_t'(v);
    endfunction

    ////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////
    task automatic end_run();
        $display("Errors: %0d mismatches, %0d protocol, %0d timeouts",
                 mismatches, mon_errs + protocol_errs, timeouts);
        if (mismatches + mon_errs + protocol_errs + timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            $display("Timeout: busy stayed high for %0d cycles", WAIT_LIMIT);
            timeouts++;
            end_run();
        end
    endtask

    task automatic wait_done(input int count);
        int n;
        n = 0;
        while (done_cnt < count && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (done_cnt < count) begin
            $display("Timeout: tile %0d never signalled tile_done", count - 1);
            timeouts++;
            end_run();
        end
    endtask

    task automatic wait_credits();
        int n;
        n = 0;
        while (ret_cnt != recv_cnt && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (ret_cnt != recv_cnt) begin
            $display("Timeout: consumer still holds %0d credits", recv_cnt - ret_cnt);
            timeouts++;
            end_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // One tile: build data, predict, stream
    ////////////////////////////////////////////////////////////
    task automatic run_tile(input int t);
        conv_types_pkg::pix_t      pix_mem [MAX_PIX];
        conv_types_pkg::wgt_vec_t  wgt_mem [MAX_PIX];
        conv_types_pkg::bias_vec_t bias_v;
        conv_types_pkg::out_word_t word;
        int                        dot [conv_types_pkg::SA_ROWS];
        int                        lp;
        logic                      leaky;
        logic                      big;
        logic [31:0]               v;

        big = (t % 4 == 2);                 // Drives sums into saturation
        take_bits(stim_lfsr, 6, v);
        if (t == 0 || t == 7) begin
            lp = 0;                         // Single-pixel tile
        end else if (big) begin
            lp = 24 + int'(v[3:0]);
        end else begin
            lp = int'(v % 41);
        end
        take_bits(stim_lfsr, 1, v);
        leaky = (t == 2) ? 1'b1 : (t == 6) ? 1'b0 : v[0];
        for (int r = 0; r < conv_types_pkg::SA_ROWS; r++) begin
            take_bits(stim_lfsr, 16, v);
            bias_v.b[r] = conv_types_pkg::bias_t'(v[15:0]);
            dot[r]      = 0;
        end
        for (int k = 0; k <= lp; k++) begin
            take_bits(stim_lfsr, 8, v);
            pix_mem[k] = big ? conv_types_pkg::pix_t'(8'h7f) : conv_types_pkg::pix_t'(v[7:0]);
            for (int r = 0; r < conv_types_pkg::SA_ROWS; r++) begin
                take_bits(stim_lfsr, 8, v);
                if (big) begin
                    wgt_mem[k].w[r] = conv_types_pkg::wgt_t'(v[0] ? 8'h7f : 8'h80);
                end else begin
                    wgt_mem[k].w[r] = conv_types_pkg::wgt_t'(v[7:0]);
                end
                dot[r] += int'(pix_mem[k]) * int'(wgt_mem[k].w[r]);
            end
        end
        for (int r = 0; r < conv_types_pkg::SA_ROWS; r++) begin
            word.row = sa_seq_pkg::row_idx_t'(r);
            word.q   = model_result(dot[r], int'(bias_v.b[r]), leaky);
            exp_q.push_back(word);
        end

        wait_idle();
        stingy = (t % 4 == 3);
        @(posedge clk);
        start     <= 1'b1;
        last_pix  <= sa_seq_pkg::pix_cnt_t'(lp);
        mode      <= leaky;
        bias      <= bias_v;
        pix_valid <= 1'b1;
        pix       <= pix_mem[0];
        wgts      <= wgt_mem[0];
        for (int k = 1; k <= lp; k++) begin
            @(posedge clk);
            start <= 1'b0;
            pix   <= pix_mem[k];
            wgts  <= wgt_mem[k];
        end
        @(posedge clk);
        take_bits(stim_lfsr, 16, v);
        start     <= (t % 2 == 1);          // Stray start, DUT is busy here
        last_pix  <= sa_seq_pkg::pix_cnt_t'(v[15:0]);
        mode      <= ~leaky;
        bias      <= conv_types_pkg::bias_vec_t'({8{v[15:0]}});
        pix_valid <= 1'b0;
        @(posedge clk);
        start <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Consumer and output monitor
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        logic [31:0] v;
        if (reset) begin
            credit_ret <= 1'b0;
            ret_cnt    <= 0;
            delay_cnt  <= 0;
        end else if (recv_cnt != ret_cnt && delay_cnt == 0) begin
            credit_ret <= 1'b1;
            ret_cnt    <= ret_cnt + 1;
            take_bits(cons_lfsr, 3, v);
            delay_cnt  <= int'(v % 7) + (stingy ? 25 : 0);
        end else begin
            credit_ret <= 1'b0;
            if (delay_cnt != 0) begin
                delay_cnt <= delay_cnt - 1;
            end
        end
    end

    always @(negedge clk) begin
        conv_types_pkg::out_word_t want;
        logic                      done_exp;
        if (!reset) begin
            done_exp = 1'b0;
            if (out_valid) begin
                recv_cnt++;
                done_exp = (recv_cnt % conv_types_pkg::SA_ROWS == 0);  // Last word of a tile
                assert (recv_cnt - ret_cnt <= sa_seq_pkg::OUT_CREDITS) else begin
                    $display("More than %0d words outstanding at the consumer",
                             sa_seq_pkg::OUT_CREDITS);
                    mon_errs++;
                end
                assert (exp_q.size() != 0) else begin
                    $display("Output word arrived with no word expected");
                    mon_errs++;
                end
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    assert (out_word.row == want.row) else begin
                        $display("Mismatch out_word.row: got %h, expected %h",
                                 out_word.row, want.row);
                        mismatches++;
                    end
                    assert (out_word.q == want.q) else begin
                        $display("Mismatch out_word.q: got %h, expected %h",
                                 out_word.q, want.q);
                        mismatches++;
                    end
                end
            end
            assert (tile_done == done_exp) else begin
                $display("Mismatch tile_done: got %h, expected %h", tile_done, done_exp);
                mismatches++;
            end
            if (tile_done) begin
                done_cnt++;
            end
            assert (busy == busy_exp) else begin
                $display("Mismatch busy: got %h, expected %h", busy, busy_exp);
                mismatches++;
            end
            // Busy from the cycle after an accepted start through tile_done
            if (start && !busy_exp) begin
                busy_exp = 1'b1;
            end else if (done_exp) begin
                busy_exp = 1'b0;
            end
        end
    end

    initial begin
        reset     <= 1'b1;
        start     <= 1'b0;
        last_pix  <= '0;
        pix_valid <= 1'b0;
        pix       <= '0;
        wgts      <= '0;
        bias      <= '0;
        mode      <= 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (int t = 0; t < NUM_TILES; t++) begin
            run_tile(t);
            wait_done(t + 1);
        end
        wait_credits();
        assert (exp_q.size() == 0) else begin
            $display("%0d expected words never arrived", exp_q.size());
            protocol_errs++;
        end
        assert (recv_cnt == NUM_TILES * conv_types_pkg::SA_ROWS) else begin
            $display("Received %0d words in total instead of %0d", recv_cnt,
                     NUM_TILES * conv_types_pkg::SA_ROWS);
            protocol_errs++;
        end
        assert (done_cnt == NUM_TILES) else begin
            $display("Saw %0d tile_done pulses for %0d tiles", done_cnt, NUM_TILES);
            protocol_errs++;
        end
        end_run();
    end

endmodule

/* files.f */
rtl/conv_types_pkg.sv
rtl/sa_seq_pkg.sv
rtl/sa_ctrl.sv
rtl/sa_array.sv
rtl/post_proc.sv
rtl/conv_tile_top.sv
tb/conv_tile_sva.sv
tb/conv_tile_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the conv tile testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module conv_tile_tb -Mdir obj_dir -o conv_tile_sim -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/conv_tile_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF '*** FAILED ***' "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
exit 0
